//--- Makefile
TOP := ioClkGenTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

//--- logic/clkGenPkg.sv
package clkGenPkg;

    // Divisor and tick counter width
    localparam int divisorWidth = 14;

    // Which strobe advances the divider
    typedef enum logic [1:0] {
        // Count on every enabled cycle
        srcEvery = 2'd0,
        // External strobes
        srcTick0 = 2'd1,
        srcTick1 = 2'd2,
        srcTick2 = 2'd3
    } tickSource_e;

endpackage

//--- logic/clockDivider.sv
module clockDivider (
    input  logic                                    divided_clk_src,
    input  logic                                    rstN,
    input  logic                                    clkEn,
    input  logic                                    tick0,
    input  logic                                    tick1,
    input  logic                                    tick2,
    input  logic [configLayoutPkg::configWidth-1:0] headWord,
    input  logic                                    notEmpty,
    output logic                                    pop,
    output logic                                    dividedClk,
    output clkGenPkg::tickSource_e                  dividedClkSel
);
    import clkGenPkg::*;
    import configLayoutPkg::*;

    // Configuration currently in effect
    logic [divisorWidth-1:0] activeDivisor;
    tickSource_e             activeSel;

    // Next configuration from the queue head
    logic [divisorWidth-1:0] headDivisor;
    tickSource_e             headSel;

    logic [divisorWidth-1:0] tickCount;
    logic                    clkFF;
    logic                    countedTick;
    logic                    boundary;

    assign headDivisor = headWord[selectLsb-1:0];
    assign headSel     = tickSource_e'(headWord[configWidth-1:selectLsb]);

    // Tick source mux
    always_comb begin
        case (activeSel)
            srcTick0: countedTick = tick0;
            srcTick1: countedTick = tick1;
            srcTick2: countedTick = tick2;
            default:  countedTick = 1'b1;
        endcase
    end

    // Half-period ends on the tick that matches the divisor
    assign boundary = clkEn && countedTick && (tickCount == activeDivisor);

    // Only swap config at a boundary so the output stays clean
    assign pop = boundary && notEmpty;

    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            tickCount <= '0;
            clkFF     <= 1'b0;
        end else if (boundary) begin
            tickCount <= '0;
            clkFF     <= ~clkFF;
        end else if (clkEn && countedTick) begin
            tickCount <= tickCount + divisorWidth'(1);
        end
    end

    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            activeDivisor <= '0;
            activeSel     <= srcEvery;
        end else if (pop) begin
            activeDivisor <= headDivisor;
            activeSel     <= headSel;
        end
    end

    assign dividedClk    = clkFF;
    assign dividedClkSel = activeSel;

endmodule

//--- logic/configLayoutPkg.sv
package configLayoutPkg;

    // Full configuration word, written as two bytes
    localparam int configWidth = 16;

    // Select field sits on top, divisor fills the bits below it
    localparam int selectLsb = 14;

    // Pending configurations held between submit and load
    localparam int defaultQueueDepth = 4;

endpackage

//--- logic/configQueue.sv
module configQueue #(
    parameter int depth = configLayoutPkg::defaultQueueDepth
) (
    input  logic                                    divided_clk_src,
    input  logic                                    rstN,
    input  logic                                    clkEn,
    input  logic                                    push,
    input  logic [configLayoutPkg::configWidth-1:0] pushWord,
    input  logic                                    pop,
    output logic [configLayoutPkg::configWidth-1:0] headWord,
    output logic                                    notEmpty,
    output logic                                    full
);
    import configLayoutPkg::*;

    localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0]   lastSlot  = ptrWidth'(depth - 1);
    localparam logic [countWidth-1:0] fullCount = countWidth'(depth);

    logic [configWidth-1:0] storage [depth];
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [countWidth-1:0]  count;
    logic                   pushOk;
    logic                   popOk;

    // Wraps at depth, so any depth works
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == lastSlot) begin
            return '0;
        end
        return ptr + ptrWidth'(1);
    endfunction

    // Pushes while full are dropped
    assign pushOk = clkEn && push && !full;
    assign popOk  = clkEn && pop && notEmpty;

    always_ff @(posedge divided_clk_src) begin
        if (pushOk) begin
            storage[wrPtr] <= pushWord;
        end
    end

    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushOk) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popOk) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushOk, popOk})
                2'b10:   count <= count + countWidth'(1);
                2'b01:   count <= count - countWidth'(1);
                // Both or neither leaves occupancy alone
                default: count <= count;
            endcase
        end
    end

    assign headWord = storage[rdPtr];
    assign notEmpty = (count != '0);
    assign full     = (count == fullCount);

endmodule

//--- logic/configRegs.sv
module configRegs (
    input  logic                                    divided_clk_src,
    input  logic                                    rstN,
    input  logic                                    clkEn,
    input  logic                                    writeEnUpper,
    input  logic                                    writeEnLower,
    input  logic [7:0]                              configIn,
    output logic [configLayoutPkg::configWidth-1:0] configOut,
    output logic                                    submit,
    output logic [configLayoutPkg::configWidth-1:0] submitWord
);
    import configLayoutPkg::*;

    localparam int byteWidth = configWidth / 2;

    logic [byteWidth-1:0] upperByte;
    logic [byteWidth-1:0] lowerByte;
    // Stage 0 marks an upper write, stage 1 fires submit
    logic [1:0]           submitDelay;

    // Upper byte holds select and top of divisor
    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            upperByte <= '0;
        end else if (clkEn && writeEnUpper) begin
            upperByte <= configIn;
        end
    end

    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            lowerByte <= '0;
        end else if (clkEn && writeEnLower) begin
            lowerByte <= configIn;
        end
    end

    // Two enabled cycles between upper write and submit
    always_ff @(posedge divided_clk_src) begin
        if (!rstN) begin
            submitDelay <= 2'b00;
        end else if (clkEn) begin
            submitDelay[0] <= writeEnUpper;
            submitDelay[1] <= submitDelay[0];
        end
    end

    // Pulse only lasts for the enabled cycle
    assign submit = submitDelay[1] && clkEn;

    assign configOut  = {upperByte, lowerByte};
    // Snapshot taken by the queue while submit is high
    assign submitWord = {upperByte, lowerByte};

endmodule

//--- logic/ioClkGeneration.sv
module ioClkGeneration #(
    parameter int queueDepth = configLayoutPkg::defaultQueueDepth
) (
    input  logic                                    divided_clk_src,
    input  logic                                    rstN,
    input  logic                                    clkEn,
    input  logic                                    writeEnUpper,
    input  logic                                    writeEnLower,
    input  logic [7:0]                              configIn,
    input  logic                                    tick0,
    input  logic                                    tick1,
    input  logic                                    tick2,
    output logic [configLayoutPkg::configWidth-1:0] configOut,
    output logic                                    queueFull,
    output logic                                    dividedClk,
    output clkGenPkg::tickSource_e                  dividedClkSel
);
    import configLayoutPkg::*;

    logic                   submit;
    logic [configWidth-1:0] submitWord;
    logic [configWidth-1:0] headWord;
    logic                   notEmpty;
    logic                   pop;

    // Byte registers and submit delay
    configRegs i_configRegs (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .writeEnUpper   (writeEnUpper),
        .writeEnLower   (writeEnLower),
        .configIn       (configIn),
        .configOut      (configOut),
        .submit         (submit),
        .submitWord     (submitWord)
    );

    // Pending configurations wait here until the next boundary
    configQueue #(
        .depth(queueDepth)
    ) i_configQueue (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .push           (submit),
        .pushWord       (submitWord),
        .pop            (pop),
        .headWord       (headWord),
        .notEmpty       (notEmpty),
        .full           (queueFull)
    );

    clockDivider i_clockDivider (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .tick0          (tick0),
        .tick1          (tick1),
        .tick2          (tick2),
        .headWord       (headWord),
        .notEmpty       (notEmpty),
        .pop            (pop),
        .dividedClk     (dividedClk),
        .dividedClkSel  (dividedClkSel)
    );

endmodule

//--- tests/ioClkGenModel.svh
`ifndef IO_CLK_GEN_MODEL_SVH
`define IO_CLK_GEN_MODEL_SVH

// Reference state, advanced once per rising edge
logic [7:0]              mUpper;
logic [7:0]              mLower;
logic [1:0]              mDelay;
logic [configWidth-1:0]  mQueue[$];
logic [divisorWidth-1:0] mDivisor;
tickSource_e             mSel;
logic [divisorWidth-1:0] mCount;
logic                    mClk;

task automatic modelStep(
    input logic       rst,
    input logic       en,
    input logic       wu,
    input logic       wl,
    input logic [7:0] cfg,
    input logic       t0,
    input logic       t1,
    input logic       t2
);
    logic                   counted;
    logic                   boundary;
    logic                   doPush;
    logic [configWidth-1:0] word;
    if (!rst) begin
        mUpper   = '0;
        mLower   = '0;
        mDelay   = '0;
        mQueue.delete();
        mDivisor = '0;
        mSel     = srcEvery;
        mCount   = '0;
        mClk     = 1'b0;
    end else if (en) begin
        // Everything below uses the state from before this edge
        word     = {mUpper, mLower};
        doPush   = mDelay[1] && (mQueue.size() < defaultQueueDepth);
        counted  = (mSel == srcEvery) || (mSel == srcTick0 && t0)
                   || (mSel == srcTick1 && t1) || (mSel == srcTick2 && t2);
        boundary = counted && (mCount == mDivisor);
        if (boundary) begin
            mClk   = !mClk;
            mCount = '0;
            if (mQueue.size() != 0) begin
                mDivisor = mQueue[0][selectLsb-1:0];
                mSel     = tickSource_e'(mQueue[0][configWidth-1:selectLsb]);
                void'(mQueue.pop_front());
            end
        end else if (counted) begin
            mCount = mCount + divisorWidth'(1);
        end
        if (doPush) begin
            mQueue.push_back(word);
        end
        if (wu) begin
            mUpper = cfg;
        end
        if (wl) begin
            mLower = cfg;
        end
        mDelay = {mDelay[0], wu};
    end
endtask

task automatic compareWord(
    input string                  what,
    input logic [configWidth-1:0] expected,
    input logic [configWidth-1:0] actual
);
    if (actual !== expected) begin
        $display("Fail %s: %s expected %h actual %h", currentTest, what, expected, actual);
        testErrors++;
    end
endtask

task automatic compareBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Fail %s: %s expected %b actual %b", currentTest, what, expected, actual);
        testErrors++;
    end
endtask

task automatic compareSel(
    input string       what,
    input tickSource_e expected,
    input tickSource_e actual
);
    if (actual !== expected) begin
        $display("Fail %s: %s expected %s actual %s", currentTest, what,
                 expected.name(), actual.name());
        testErrors++;
    end
endtask

`endif

//--- tests/ioClkGenTb.sv
module ioClkGenTb;
    import clkGenPkg::*;
    import configLayoutPkg::*;

    localparam int clockPeriod    = 10;
    localparam int resetCycles    = 2;
    localparam int readbackCycles = 60;
    localparam int gatingCycles   = 200;
    localparam int everyRounds    = 6;
    localparam int everyWait      = 40;
    localparam int tickWait       = 80;
    localparam int settleCycles   = 8;
    localparam int burstWrites    = 7;
    localparam int drainCycles    = 300;
    localparam int watchdogCycles = resetCycles * 5 + readbackCycles + gatingCycles
                                    + everyRounds * (2 + everyWait) + 3 * (2 + tickWait)
                                    + 2 + settleCycles + burstWrites + drainCycles + 50;

    logic                   divided_clk_src;
    logic                   rstN;
    logic                   clkEn;
    logic                   writeEnUpper;
    logic                   writeEnLower;
    logic [7:0]             configIn;
    logic                   tick0;
    logic                   tick1;
    logic                   tick2;
    logic [configWidth-1:0] configOut;
    logic                   queueFull;
    logic                   dividedClk;
    tickSource_e            dividedClkSel;

    string currentTest;
    int    testErrors;
    int    totalErrors;
    int    testsRun;
    int    testsFailed;
    logic  rstDrive;

    `include "ioClkGenModel.svh"

    ioClkGeneration #(
        .queueDepth(defaultQueueDepth)
    ) i_dut (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .writeEnUpper   (writeEnUpper),
        .writeEnLower   (writeEnLower),
        .configIn       (configIn),
        .tick0          (tick0),
        .tick1          (tick1),
        .tick2          (tick2),
        .configOut      (configOut),
        .queueFull      (queueFull),
        .dividedClk     (dividedClk),
        .dividedClkSel  (dividedClkSel)
    );

    initial begin
        divided_clk_src = 1'b0;
        forever #(clockPeriod / 2) divided_clk_src = ~divided_clk_src;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Something failed");
        $finish;
    end

    task automatic checkOutputs();
        compareWord("configOut", {mUpper, mLower}, configOut);
        compareBit("dividedClk", mClk, dividedClk);
        compareBit("queueFull", mQueue.size() == defaultQueueDepth, queueFull);
        compareSel("dividedClkSel", mSel, dividedClkSel);
    endtask

    // Model takes what the DUT samples at this edge and new values land for the next one
    task automatic stepCycle(
        input logic       en,
        input logic       wu,
        input logic       wl,
        input logic [7:0] cfg,
        input logic       t0,
        input logic       t1,
        input logic       t2
    );
        @(posedge divided_clk_src);
        modelStep(rstN, clkEn, writeEnUpper, writeEnLower, configIn, tick0, tick1, tick2);
        rstN         <= rstDrive;
        clkEn        <= en;
        writeEnUpper <= wu;
        writeEnLower <= wl;
        configIn     <= cfg;
        tick0        <= t0;
        tick1        <= t1;
        tick2        <= t2;
        @(negedge divided_clk_src);
        checkOutputs();
    endtask

    task automatic idleCycle(input logic en);
        stepCycle(en, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic writeLower(input logic [7:0] value);
        stepCycle(1'b1, 1'b0, 1'b1, value, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic writeUpper(input logic [7:0] value);
        stepCycle(1'b1, 1'b1, 1'b0, value, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic resetDut();
        rstDrive = 1'b0;
        repeat (resetCycles) idleCycle(1'b0);
        rstDrive = 1'b1;
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic finishTest();
        $display("Test %s finished with %0d mismatches", currentTest, testErrors);
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
        end
    endtask

    task automatic gateRandomly();
        int         kind;
        logic [7:0] cfgByte;
        repeat (gatingCycles) begin
            kind = $urandom_range(0, 3);
            // Upper writes keep the divisor small so the output moves
            if (kind == 0) begin
                cfgByte = {2'($urandom_range(0, 3)), 6'b000000};
            end else begin
                cfgByte = 8'($urandom_range(0, 7));
            end
            stepCycle(1'($urandom_range(0, 1)), kind == 0, kind == 1, cfgByte,
                      1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                      1'($urandom_range(0, 1)));
        end
    endtask

    task automatic divideOnEvery();
        repeat (everyRounds) begin
            writeLower(8'($urandom_range(0, 6)));
            writeUpper(8'h00);
            repeat (everyWait) idleCycle(1'b1);
        end
    endtask

    task automatic sweepTickSources();
        for (int s = 1; s < 4; s++) begin
            writeLower(8'($urandom_range(0, 3)));
            writeUpper({2'(s), 6'b000000});
            repeat (tickWait) begin
                stepCycle(1'b1, 1'b0, 1'b0, 8'h00, 1'($urandom_range(0, 1)),
                          1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
            end
        end
    endtask

    task automatic overflowQueue();
        // Divisor 20 holds the boundary off while the burst fills the queue
        writeLower(8'd20);
        writeUpper(8'h00);
        repeat (settleCycles) idleCycle(1'b1);
        // Words past the queue depth carry a larger divisor than the kept ones
        for (int i = 0; i < burstWrites; i++) begin
            writeUpper({2'(i % 4), 6'(i / 4)});
        end
        repeat (drainCycles) begin
            stepCycle(1'b1, 1'b0, 1'b0, 8'h00, $urandom_range(0, 3) != 0,
                      $urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0);
        end
    endtask

    initial begin
        rstN         = 1'b0;
        clkEn        = 1'b0;
        writeEnUpper = 1'b0;
        writeEnLower = 1'b0;
        configIn     = 8'h00;
        tick0        = 1'b0;
        tick1        = 1'b0;
        tick2        = 1'b0;
        rstDrive     = 1'b0;
        totalErrors  = 0;
        testsRun     = 0;
        testsFailed  = 0;
        void'($urandom(32'hc63d));

        startTest("readback");
        idleCycle(1'b0);
        rstDrive = 1'b1;
        idleCycle(1'b0);
        repeat (readbackCycles) begin
            stepCycle(1'b1, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                      8'($urandom_range(0, 255)), 1'b0, 1'b0, 1'b0);
        end
        finishTest();

        startTest("clkEnGating");
        resetDut();
        gateRandomly();
        finishTest();

        startTest("divideEvery");
        resetDut();
        divideOnEvery();
        finishTest();

        startTest("tickSources");
        resetDut();
        sweepTickSources();
        finishTest();

        startTest("queueOverflow");
        resetDut();
        overflowQueue();
        finishTest();

        $display("Tests run %0d, tests failed %0d, mismatches %0d",
                 testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
logic/clkGenPkg.sv
logic/configLayoutPkg.sv
logic/configRegs.sv
logic/configQueue.sv
logic/clockDivider.sv
logic/ioClkGeneration.sv
tests/ioClkGenTb.sv
